//--- hdl/network_macros.svh
`ifndef NETWORK_MACROS_SVH
`define NETWORK_MACROS_SVH

`default_nettype none

// Layer sizes of the classifier.
`define FEATURE_COUNT 5
`define HIDDEN_COUNT 5
`define CLASS_COUNT 4

// Activations and weights are fixed point with 6 fraction bits.
`define ACT_WIDTH 8
`define WEIGHT_WIDTH 8

// Biases sit at the scale of a product, so they carry 12 fraction bits.
`define BIAS_WIDTH 16
`define PRODUCT_WIDTH 16
`define ACC_WIDTH 23

// Lowest accumulator bit that survives into an activation.
`define FRAC_SHIFT 6
`define ACT_MAX 127

// Weight tables are node-major. Each line is one node, listed from the highest node down,
// and within a line the inputs run from the highest down to input 0.
// The rightmost entry is therefore node 0, input 0, which lands in bits 7 to 0.
`define HIDDEN_WEIGHTS { \
	8'sd26, 8'sd18, 8'sd12, -8'sd35, -8'sd7, \
	-8'sd27, 8'sd22, -8'sd16, 8'sd3, 8'sd40, \
	8'sd14, -8'sd9, 8'sd30, 8'sd25, -8'sd18, \
	-8'sd5, 8'sd33, 8'sd7, -8'sd12, 8'sd20, \
	8'sd31, -8'sd31, -8'sd23, 8'sd15, 8'sd9 \
}

`define HIDDEN_BIASES { \
	16'sd768, -16'sd256, 16'sd0, 16'sd512, -16'sd1024 \
}

`define OUTPUT_WEIGHTS { \
	8'sd27, 8'sd11, 8'sd20, 8'sd9, -8'sd25, \
	8'sd5, -8'sd18, 8'sd30, 8'sd14, 8'sd22, \
	8'sd16, 8'sd24, -8'sd6, 8'sd28, -8'sd12, \
	-8'sd8, 8'sd10, 8'sd15, -8'sd20, 8'sd30 \
}

`define OUTPUT_BIASES { \
	-16'sd128, 16'sd128, -16'sd512, 16'sd256 \
}

`default_nettype wire

`endif

//--- hdl/networkPkg.sv
`include "network_macros.svh"

`default_nettype none

package networkPkg;

	// Value passed between layers and fed in as a feature.
	typedef logic signed [`ACT_WIDTH-1:0] activation;

	// Coefficient applied to one node input.
	typedef logic signed [`WEIGHT_WIDTH-1:0] weight;

	// Offset added to a node sum, already at the scale of a product.
	typedef logic signed [`BIAS_WIDTH-1:0] bias;

	// One activation times one weight, 12 fraction bits.
	typedef logic signed [`PRODUCT_WIDTH-1:0] product;

	// Sum of all products and the bias of a node.
	// Seven guard bits keep it from overflowing for any input count used here.
	typedef logic signed [`ACC_WIDTH-1:0] accumulator;

	// Number of an output class.
	typedef logic [$clog2(`CLASS_COUNT)-1:0] classIndex;

endpackage

`default_nettype wire

//--- hdl/neuronNode.sv
`include "network_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module neuronNode
	import networkPkg::*;
#(
	parameter int INPUTS = `FEATURE_COUNT,
	parameter logic [INPUTS*`WEIGHT_WIDTH-1:0] WEIGHTS = '0,
	parameter bias BIAS = '0
)
(
	input wire logic clk,
	input wire logic reset,
	input wire activation [INPUTS-1:0] inputs,
	output activation result
);

	// Accumulator bits that must all be clear for the result to fit.
	localparam int OVF_HI = `ACC_WIDTH - 2;
	localparam int OVF_LO = `FRAC_SHIFT + `ACT_WIDTH - 1;

	activation [INPUTS-1:0] inputsReg; // First pipeline stage.
	product products [INPUTS];
	accumulator sumNext;
	accumulator sum; // Second pipeline stage.
	activation activationNext;
	logic negative;
	logic overflow;
	logic roundUp;

	// One multiplier per input, each with its own constant weight.
	for (genvar i = 0; i < INPUTS; i++)
	begin : gProduct
		localparam weight W = WEIGHTS[i*`WEIGHT_WIDTH +: `WEIGHT_WIDTH];

		assign products[i] = inputsReg[i] * W;
	end

	// The casts sign-extend every term to the full accumulator width.
	always_comb
	begin
		sumNext = accumulator'(BIAS);
		for (int i = 0; i < INPUTS; i++)
		begin
			sumNext = sumNext + accumulator'(products[i]);
		end
	end

	assign negative = sum[`ACC_WIDTH-1];
	assign overflow = (sum[OVF_HI:OVF_LO] != '0);
	assign roundUp = sum[`FRAC_SHIFT-1]; // Half an output step.

	// Rectify, saturate, then round to nearest.
	// A rounded 127 wraps to 8'h80, matching the original node behaviour.
	always_comb
	begin
		if (negative)
		begin
			activationNext = '0;
		end
		else if (overflow)
		begin
			activationNext = activation'(`ACT_MAX);
		end
		else
		begin
			activationNext = sum[`FRAC_SHIFT +: `ACT_WIDTH] + `ACT_WIDTH'(roundUp);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sum <= '0;
			result <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sum <= sumNext;
			result <= activationNext; // Third stage, three cycles after the inputs.
		end
	end

endmodule

`default_nettype wire

//--- hdl/classSelect.sv
`include "network_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module classSelect
	import networkPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire activation [`CLASS_COUNT-1:0] scores,
	output classIndex bestClass,
	output activation bestScore
);

	classIndex maxIndex;
	activation maxScore;

	// Linear scan over the scores.
	// The comparison is strict, so on a tie the lowest index is kept.
	always_comb
	begin
		maxIndex = '0;
		maxScore = activation'(scores[0]);
		for (int i = 1; i < `CLASS_COUNT; i++)
		begin
			if (activation'(scores[i]) > maxScore)
			begin
				maxIndex = classIndex'(i);
				maxScore = activation'(scores[i]);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestClass <= '0;
			bestScore <= '0;
		end
		else
		begin
			bestClass <= maxIndex;
			bestScore <= maxScore; // Signed, so a wrapped 8'h80 never wins.
		end
	end

endmodule

`default_nettype wire

//--- hdl/classifierTop.sv
`include "network_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module classifierTop
	import networkPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire activation feature0,
	input wire activation feature1,
	input wire activation feature2,
	input wire activation feature3,
	input wire activation feature4,
	output activation score0,
	output activation score1,
	output activation score2,
	output activation score3,
	output classIndex bestClass,
	output activation bestScore
);

	// Bits of weights belonging to one node of each layer.
	localparam int HIDDEN_SPAN = `FEATURE_COUNT * `WEIGHT_WIDTH;
	localparam int OUTPUT_SPAN = `HIDDEN_COUNT * `WEIGHT_WIDTH;

	localparam logic [`HIDDEN_COUNT*HIDDEN_SPAN-1:0] HIDDEN_W = `HIDDEN_WEIGHTS;
	localparam logic [`HIDDEN_COUNT*`BIAS_WIDTH-1:0] HIDDEN_B = `HIDDEN_BIASES;
	localparam logic [`CLASS_COUNT*OUTPUT_SPAN-1:0] OUTPUT_W = `OUTPUT_WEIGHTS;
	localparam logic [`CLASS_COUNT*`BIAS_WIDTH-1:0] OUTPUT_B = `OUTPUT_BIASES;

	activation [`FEATURE_COUNT-1:0] features;
	activation [`HIDDEN_COUNT-1:0] hidden;
	activation [`CLASS_COUNT-1:0] scores;

	assign features = {feature4, feature3, feature2, feature1, feature0};

	// Hidden layer. Every node sees all features.
	for (genvar n = 0; n < `HIDDEN_COUNT; n++)
	begin : gHidden
		neuronNode #(
			.INPUTS(`FEATURE_COUNT),
			.WEIGHTS(HIDDEN_W[n*HIDDEN_SPAN +: HIDDEN_SPAN]),
			.BIAS(bias'(HIDDEN_B[n*`BIAS_WIDTH +: `BIAS_WIDTH]))
		) node (
			.clk(clk),
			.reset(reset),
			.inputs(features),
			.result(hidden[n])
		);
	end

	// Output layer, three cycles behind the hidden layer.
	for (genvar n = 0; n < `CLASS_COUNT; n++)
	begin : gOutput
		neuronNode #(
			.INPUTS(`HIDDEN_COUNT),
			.WEIGHTS(OUTPUT_W[n*OUTPUT_SPAN +: OUTPUT_SPAN]),
			.BIAS(bias'(OUTPUT_B[n*`BIAS_WIDTH +: `BIAS_WIDTH]))
		) node (
			.clk(clk),
			.reset(reset),
			.inputs(hidden),
			.result(scores[n])
		);
	end

	assign score0 = scores[0];
	assign score1 = scores[1];
	assign score2 = scores[2];
	assign score3 = scores[3];

	// One more register stage picks the winner.
	classSelect selector (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.bestClass(bestClass),
		.bestScore(bestScore)
	);

endmodule

`default_nettype wire

//--- tb/classifier_props.sv
`include "network_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module classifierProps
	import networkPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire activation [`CLASS_COUNT-1:0] scores,
	input wire classIndex bestClass,
	input wire activation bestScore
);

	int failures = 0; // Summed into the testbench result.

	// Both outputs clear one cycle after reset.
	assert property (@(posedge clk) reset |=> (bestClass == '0) && (bestScore == '0))
	else
	begin
		failures++;
		$error("bestClass or bestScore is not zero after reset");
	end

	for (genvar i = 0; i < `CLASS_COUNT; i++)
	begin : gPerClass
		// The winner is never below any candidate of the cycle before.
		assert property (@(posedge clk)
			!reset |=> $signed(bestScore) >= $signed($past(scores[i])))
		else
		begin
			failures++;
			$error("bestScore is below a score of the previous cycle");
		end

		assert property (@(posedge clk)
			!reset ##1 (bestClass == i) |-> bestScore == $past(scores[i])) // Score follows index.
		else
		begin
			failures++;
			$error("bestScore does not match the score at bestClass");
		end
	end

endmodule

`default_nettype wire

//--- tb/classifierTb.sv
`include "network_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module classifierTb
	import networkPkg::*;
();

	localparam int ROWS = 12;
	localparam int HAND_ROWS = 5;
	localparam int RESET_CYCLES = 4;
	localparam int SCORE_LATENCY = 6;
	localparam int CLASS_LATENCY = 7;
	localparam int CYCLE_LIMIT = RESET_CYCLES + ROWS + CLASS_LATENCY + 20;

	// Reset clears both the sum and the result register of a node, so its first two
	// results are zero. After that the pipeline carries the bias response until row 0 arrives.
	localparam int CLEAR_CYCLES = 2;

	localparam int HW_BITS = `HIDDEN_COUNT * `FEATURE_COUNT * `WEIGHT_WIDTH;
	localparam int OW_BITS = `CLASS_COUNT * `HIDDEN_COUNT * `WEIGHT_WIDTH;

	localparam logic [HW_BITS-1:0] HIDDEN_W = `HIDDEN_WEIGHTS;
	localparam logic [`HIDDEN_COUNT*`BIAS_WIDTH-1:0] HIDDEN_B = `HIDDEN_BIASES;
	localparam logic [OW_BITS-1:0] OUTPUT_W = `OUTPUT_WEIGHTS;
	localparam logic [`CLASS_COUNT*`BIAS_WIDTH-1:0] OUTPUT_B = `OUTPUT_BIASES;

	logic clk;
	logic reset;
	activation feature0;
	activation feature1;
	activation feature2;
	activation feature3;
	activation feature4;
	activation score0;
	activation score1;
	activation score2;
	activation score3;
	classIndex bestClass;
	activation bestScore;

	activation stimTable [ROWS][`FEATURE_COUNT];
	activation expScore [ROWS][`CLASS_COUNT];
	classIndex expClass [ROWS];
	activation expBest [ROWS];
	int rowErrors [ROWS];
	int idleErrors;
	int seed;
	int checks;
	int errors;
	int propFailures;
	int cycleCount;

	classifierTop uut (
		.clk(clk),
		.reset(reset),
		.feature0(feature0),
		.feature1(feature1),
		.feature2(feature2),
		.feature3(feature3),
		.feature4(feature4),
		.score0(score0),
		.score1(score1),
		.score2(score2),
		.score3(score3),
		.bestClass(bestClass),
		.bestScore(bestScore)
	);

	bind classSelect classifierProps props (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.bestClass(bestClass),
		.bestScore(bestScore)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int hiddenWeight(input int node, input int index);
		return int'(weight'(HIDDEN_W[(node*`FEATURE_COUNT + index)*`WEIGHT_WIDTH +: `WEIGHT_WIDTH]));
	endfunction

	function automatic int outputWeight(input int node, input int index);
		return int'(weight'(OUTPUT_W[(node*`HIDDEN_COUNT + index)*`WEIGHT_WIDTH +: `WEIGHT_WIDTH]));
	endfunction

	function automatic int hiddenBias(input int node);
		return int'(bias'(HIDDEN_B[node*`BIAS_WIDTH +: `BIAS_WIDTH]));
	endfunction

	function automatic int outputBias(input int node);
		return int'(bias'(OUTPUT_B[node*`BIAS_WIDTH +: `BIAS_WIDTH]));
	endfunction

	// The sum never reaches bit 22, so a set bit among 21 to 13 means at least 2**13.
	function automatic activation activate(input int acc);
		int kept;
		if (acc < 0)
			return '0;
		if (acc >= (1 << (`FRAC_SHIFT + `ACT_WIDTH - 1)))
			return activation'(`ACT_MAX);
		kept = (acc >>> `FRAC_SHIFT) + ((acc >>> (`FRAC_SHIFT - 1)) & 1);
		return activation'(kept); // 127 plus a round bit wraps to 8'h80.
	endfunction

	task automatic fillRow(input int row, input int f0, input int f1, input int f2,
		input int f3, input int f4);
		stimTable[row][0] = activation'(f0);
		stimTable[row][1] = activation'(f1);
		stimTable[row][2] = activation'(f2);
		stimTable[row][3] = activation'(f3);
		stimTable[row][4] = activation'(f4);
	endtask

	task automatic predictRow(input int row);
		int acc;
		int best;
		activation hiddenAct [`HIDDEN_COUNT];
		for (int n = 0; n < `HIDDEN_COUNT; n++)
		begin
			acc = hiddenBias(n);
			for (int i = 0; i < `FEATURE_COUNT; i++)
				acc += int'(stimTable[row][i]) * hiddenWeight(n, i);
			hiddenAct[n] = activate(acc);
		end
		for (int c = 0; c < `CLASS_COUNT; c++)
		begin
			acc = outputBias(c);
			for (int n = 0; n < `HIDDEN_COUNT; n++)
				acc += int'(hiddenAct[n]) * outputWeight(c, n);
			expScore[row][c] = activate(acc);
		end
		best = 0;
		for (int c = 1; c < `CLASS_COUNT; c++)
		begin
			if (expScore[row][c] > expScore[row][best])
				best = c; // Strictly greater, so ties keep the lower index.
		end
		expClass[row] = classIndex'(best);
		expBest[row] = expScore[row][best];
	endtask

	task automatic checkValue(input string name, input int cycle, input int row,
		input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("Mismatch %s (cycle %0d, row %0d): expected %h, got %h",
				name, cycle, row, expected, actual);
			errors++;
			if (row >= 0)
				rowErrors[row]++;
			else
				idleErrors++;
		end
	endtask

	task automatic checkCycle(input int cycle);
		int row;
		activation actual [`CLASS_COUNT];
		actual = '{score0, score1, score2, score3};
		row = cycle - SCORE_LATENCY;
		for (int c = 0; c < `CLASS_COUNT; c++)
		begin
			if (cycle < CLEAR_CYCLES)
				checkValue($sformatf("score%0d", c), cycle, -1, 8'h00, actual[c]);
			else if (row >= 0 && row < ROWS)
				checkValue($sformatf("score%0d", c), cycle, row, expScore[row][c], actual[c]);
		end
		row = cycle - CLASS_LATENCY;
		if (cycle <= CLEAR_CYCLES)
		begin
			checkValue("bestClass", cycle, -1, 8'h00, 8'(bestClass));
			checkValue("bestScore", cycle, -1, 8'h00, bestScore);
			if (cycle == CLEAR_CYCLES)
				$display("Test idle: outputs zero after reset, %0d errors", idleErrors);
		end
		else if (row >= 0)
		begin
			checkValue("bestClass", cycle, row, 8'(expClass[row]), 8'(bestClass));
			checkValue("bestScore", cycle, row, expBest[row], bestScore);
			$display("Test row %0d: features %h %h %h %h %h, class %0d score %h, %0d errors",
				row, stimTable[row][0], stimTable[row][1], stimTable[row][2],
				stimTable[row][3], stimTable[row][4], expClass[row], expBest[row],
				rowErrors[row]);
		end
	endtask

	task automatic driveRow(input int cycle);
		if (cycle < ROWS)
		begin
			feature0 = stimTable[cycle][0];
			feature1 = stimTable[cycle][1];
			feature2 = stimTable[cycle][2];
			feature3 = stimTable[cycle][3];
			feature4 = stimTable[cycle][4];
		end
		else
		begin
			{feature4, feature3, feature2, feature1, feature0} = '0;
		end
	endtask

	initial
	begin
		seed = 32'h683c5b59;
		checks = 0;
		errors = 0;
		idleErrors = 0;
		reset = 1'b1;
		{feature4, feature3, feature2, feature1, feature0} = '0;
		fillRow(0, 0, 0, 0, 0, 0); // Output node 1 goes negative.
		fillRow(1, 0, 0, 0, 0, 3); // Scores 2 and 3 tie.
		fillRow(2, 127, 127, -128, 127, -128); // Hidden node 3 saturates.
		fillRow(3, 0, -8, 127, 127, 127); // Hidden node 4 rounds up into 8'h80.
		fillRow(4, -128, -128, -128, -128, -128);
		for (int r = HAND_ROWS; r < ROWS; r++)
		begin
			for (int i = 0; i < `FEATURE_COUNT; i++)
				stimTable[r][i] = activation'($random(seed));
		end
		for (int r = 0; r < ROWS; r++)
		begin
			rowErrors[r] = 0;
			predictRow(r);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		for (int cycle = 0; cycle < ROWS + CLASS_LATENCY; cycle++)
		begin
			#1;
			reset = 1'b0;
			checkCycle(cycle);
			driveRow(cycle);
			@(posedge clk);
		end
		propFailures = uut.selector.props.failures;
		$display("Summary: %0d tests, %0d checks, %0d value errors, %0d assertion failures",
			ROWS + 1, checks, errors, propFailures);
		if (errors == 0 && propFailures == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/networkPkg.sv
hdl/neuronNode.sv
hdl/classSelect.sv
hdl/classifierTop.sv
tb/classifier_props.sv
tb/classifierTb.sv

//--- Bender.yml
package:
  name: classifier

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/networkPkg.sv
  - include_dirs:
      - hdl
    files:
      - hdl/neuronNode.sv
      - hdl/classSelect.sv
      - hdl/classifierTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/classifier_props.sv
      - tb/classifierTb.sv
